// File: hdl/decode_pkg.sv
// shared widths, opcodes, operation classes and instruction word views, imported by every stage file
`default_nettype none

package decode_pkg;

    // data path and instruction widths
    localparam int xlen = 64;
    localparam int ilen = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0] xlen_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // major opcodes kept by this stage
    // fence, system and csr fall through to illegal
    typedef enum logic [6:0] {
        opc_op        = 7'b0110011,
        opc_op_32     = 7'b0111011,
        opc_op_imm    = 7'b0010011,
        opc_op_imm_32 = 7'b0011011,
        opc_load      = 7'b0000011,
        opc_store     = 7'b0100011,
        opc_branch    = 7'b1100011,
        opc_lui       = 7'b0110111,
        opc_auipc     = 7'b0010111,
        opc_jal       = 7'b1101111,
        opc_jalr      = 7'b1100111
    } opcode_e;

    // class handed to execute
    typedef enum logic [2:0] {
        cls_alu_reg = 3'd0,
        cls_alu_imm = 3'd1,
        cls_load    = 3'd2,
        cls_store   = 3'd3,
        cls_branch  = 3'd4,
        cls_upper   = 3'd5,
        cls_jump    = 3'd6,
        cls_illegal = 3'd7
    } op_class_e;

    // register-register layout
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // 12-bit immediate, loads, jalr and alu immediates
    typedef struct packed {
        logic [11:0] imm_11_0;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // stores split the immediate around rs2/rs1
    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    // branch offset, bit 0 implied
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // jal offset, bits scrambled as in the spec
    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, six ways to read it
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

endpackage

`default_nettype wire

// File: hdl/regfile_read_if.sv
// two read ports between the decode stage and the register file, one instance in the top level
`timescale 1ns/1ps
`default_nettype none

interface regfile_read_if import decode_pkg::*; ();

    // source register numbers
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;

    // operand words, combinational from the addresses
    xlen_t rs1_data;
    xlen_t rs2_data;

    // stage side, addresses out and data back
    modport requester (
        output rs1_addr,
        output rs2_addr,
        input  rs1_data,
        input  rs2_data
    );

    // register file side
    modport responder (
        input  rs1_addr,
        input  rs2_addr,
        output rs1_data,
        output rs2_data
    );

endinterface

`default_nettype wire

// File: hdl/instr_decoder.sv
// combinational decode of one instruction word into class, fields, sources used and immediate
`timescale 1ns/1ps
`default_nettype none

module instr_decoder import decode_pkg::*; (
    input  instr_u     instr,
    output op_class_e  op_class,
    output logic [2:0] funct3,
    output logic [6:0] funct7,
    output reg_addr_t  rd,
    output reg_addr_t  rs1,
    output reg_addr_t  rs2,
    output logic       uses_rs1,
    output logic       uses_rs2,
    output xlen_t      imm
);

    // one immediate per format, all sign extended to xlen
    xlen_t imm_i;
    xlen_t imm_s;
    xlen_t imm_b;
    xlen_t imm_u;
    xlen_t imm_j;

    // register fields sit at the same bits in every format
    assign rs1 = instr.r_fmt.rs1;
    assign rs2 = instr.r_fmt.rs2;

    // passed on raw, execute sorts out the operation
    assign funct3 = instr.r_fmt.funct3;
    assign funct7 = instr.r_fmt.funct7;

    assign imm_i = {{(xlen-12){instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};

    assign imm_s = {{(xlen-12){instr.s_fmt.imm_11_5[6]}},
                    instr.s_fmt.imm_11_5, instr.s_fmt.imm_4_0};

    // branch offset is in halfwords
    assign imm_b = {{(xlen-13){instr.b_fmt.imm_12}}, instr.b_fmt.imm_12,
                    instr.b_fmt.imm_11, instr.b_fmt.imm_10_5,
                    instr.b_fmt.imm_4_1, 1'b0};

    // upper 20 bits land at bit 12, then sign extend from bit 31
    assign imm_u = {{(xlen-32){instr.u_fmt.imm_31_12[19]}},
                    instr.u_fmt.imm_31_12, 12'b0};

    assign imm_j = {{(xlen-21){instr.j_fmt.imm_20}}, instr.j_fmt.imm_20,
                    instr.j_fmt.imm_19_12, instr.j_fmt.imm_11,
                    instr.j_fmt.imm_10_1, 1'b0};

    always_comb begin
        // unknown opcode: illegal, nothing read, no immediate
        op_class = cls_illegal;
        rd = instr.r_fmt.rd;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        imm = '0;
        case (instr.r_fmt.opcode)
            opc_op, opc_op_32: begin
                op_class = cls_alu_reg;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            opc_op_imm, opc_op_imm_32: begin
                // shifts keep shamt in the low imm bits
                op_class = cls_alu_imm;
                uses_rs1 = 1'b1;
                imm = imm_i;
            end
            opc_load: begin
                op_class = cls_load;
                uses_rs1 = 1'b1;
                imm = imm_i;
            end
            opc_store: begin
                // bits 11:7 are immediate here, not rd
                op_class = cls_store;
                rd = '0;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                imm = imm_s;
            end
            opc_branch: begin
                op_class = cls_branch;
                rd = '0;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                imm = imm_b;
            end
            opc_lui, opc_auipc: begin
                op_class = cls_upper;
                imm = imm_u;
            end
            opc_jal: begin
                op_class = cls_jump;
                imm = imm_j;
            end
            opc_jalr: begin
                // jalr is i-format with a base register
                op_class = cls_jump;
                uses_rs1 = 1'b1;
                imm = imm_i;
            end
            default: begin
                op_class = cls_illegal;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
// integer register file, two combinational read ports with write-back bypass and one write port
`timescale 1ns/1ps
`default_nettype none

module reg_file import decode_pkg::*; #(
    parameter int num_regs = 32
) (
    input  logic                     clk,
    input  logic                     reset,
    regfile_read_if.responder        rd_port,
    input  logic                     wr_en,
    input  reg_addr_t                wr_addr,
    input  xlen_t                    wr_data
);

    xlen_t regs [num_regs];

    // x0 reads zero, a same-cycle write wins over the stored word
    function automatic xlen_t read_port(input reg_addr_t addr);
        xlen_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wr_en && addr == wr_addr) begin
            value = wr_data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    // write on every edge with wr_en, x0 never written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // always_comb so the bypass tracks wr_* as well as the address
    always_comb begin
        rd_port.rs1_data = read_port(rd_port.rs1_addr);
    end

    always_comb begin
        rd_port.rs2_data = read_port(rd_port.rs2_addr);
    end

endmodule

`default_nettype wire

// File: hdl/decode_ctrl.sv
// stage control FSM for input acceptance, load-use stall and output back-pressure
`timescale 1ns/1ps
`default_nettype none

module decode_ctrl import decode_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid,
    input  logic      out_ready,
    input  logic      ex_load_valid,
    input  reg_addr_t ex_load_rd,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  logic      uses_rs1,
    input  logic      uses_rs2,
    output logic      in_ready,
    output logic      load_en,
    output logic      out_valid
);

    localparam logic state_empty = 1'b0;
    localparam logic state_full  = 1'b1;

    logic state;
    logic hazard;
    logic out_free;

    // load in execute writes a register this instruction reads
    // either source matching is enough
    assign hazard = ex_load_valid && (ex_load_rd != '0) &&
                    ((uses_rs1 && rs1 == ex_load_rd) ||
                     (uses_rs2 && rs2 == ex_load_rd));

    // output slot frees this edge if empty or draining
    assign out_free = (state == state_empty) || out_ready;

    assign in_ready = out_free && !hazard;
    assign load_en = in_valid && in_ready;
    assign out_valid = (state == state_full);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= state_empty;
        end else begin
            case (state)
                state_empty: begin
                    if (load_en) begin
                        state <= state_full;
                    end
                end
                default: begin
                    // refill keeps it full, drain with no refill is a bubble
                    if (load_en) begin
                        state <= state_full;
                    end else if (out_ready) begin
                        state <= state_empty;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/decode_out_reg.sv
// output register of the stage, captures decoded fields and operands when the control loads it
`timescale 1ns/1ps
`default_nettype none

module decode_out_reg import decode_pkg::*; (
    input  logic              clk,
    input  logic              load_en,
    input  xlen_t             pc,
    input  op_class_e         op_class,
    input  logic [2:0]        funct3,
    input  logic [6:0]        funct7,
    input  reg_addr_t         rd,
    input  xlen_t             imm,
    regfile_read_if.requester rd_port,
    output xlen_t             out_pc,
    output op_class_e         out_class,
    output logic [2:0]        out_funct3,
    output logic [6:0]        out_funct7,
    output reg_addr_t         out_rd,
    output xlen_t             out_imm,
    output xlen_t             out_rs1_data,
    output xlen_t             out_rs2_data
);

    // payload only, out_valid lives in the control
    // held while load_en is low, so stable under back-pressure
    always_ff @(posedge clk) begin
        if (load_en) begin
            out_pc <= pc;
            out_class <= op_class;
            out_funct3 <= funct3;
            out_funct7 <= funct7;
            out_rd <= rd;
            out_imm <= imm;
            // operands read in the accept cycle, bypass already applied
            out_rs1_data <= rd_port.rs1_data;
            out_rs2_data <= rd_port.rs2_data;
        end
    end

endmodule

`default_nettype wire

// File: hdl/decode_stage.sv
// top level of the decode and register-read stage, instantiated by the testbench as the DUT
`timescale 1ns/1ps
`default_nettype none

module decode_stage import decode_pkg::*; #(
    parameter int num_regs = 32
) (
    input  logic             clk,
    input  logic             reset,
    // instruction in
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [ilen-1:0]  in_instr,
    input  xlen_t            in_pc,
    // write-back, no handshake
    input  logic             wb_en,
    input  reg_addr_t        wb_rd,
    input  xlen_t            wb_data,
    // load in execute
    input  logic             ex_load_valid,
    input  reg_addr_t        ex_load_rd,
    // decoded result out
    output logic             out_valid,
    input  logic             out_ready,
    output xlen_t            out_pc,
    output op_class_e        out_class,
    output logic [2:0]       out_funct3,
    output logic [6:0]       out_funct7,
    output reg_addr_t        out_rd,
    output xlen_t            out_imm,
    output xlen_t            out_rs1_data,
    output xlen_t            out_rs2_data
);

    op_class_e  dec_class;
    logic [2:0] dec_funct3;
    logic [6:0] dec_funct7;
    reg_addr_t  dec_rd;
    reg_addr_t  dec_rs1;
    reg_addr_t  dec_rs2;
    logic       dec_uses_rs1;
    logic       dec_uses_rs2;
    xlen_t      dec_imm;
    logic       load_en;

    regfile_read_if rf_rd ();

    // source fields address the register file directly
    assign rf_rd.rs1_addr = dec_rs1;
    assign rf_rd.rs2_addr = dec_rs2;

    instr_decoder i_instr_decoder (
        .instr    (in_instr),
        .op_class (dec_class),
        .funct3   (dec_funct3),
        .funct7   (dec_funct7),
        .rd       (dec_rd),
        .rs1      (dec_rs1),
        .rs2      (dec_rs2),
        .uses_rs1 (dec_uses_rs1),
        .uses_rs2 (dec_uses_rs2),
        .imm      (dec_imm)
    );

    reg_file #(
        .num_regs (num_regs)
    ) i_reg_file (
        .clk     (clk),
        .reset   (reset),
        .rd_port (rf_rd.responder),
        .wr_en   (wb_en),
        .wr_addr (wb_rd),
        .wr_data (wb_data)
    );

    decode_ctrl i_decode_ctrl (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .out_ready     (out_ready),
        .ex_load_valid (ex_load_valid),
        .ex_load_rd    (ex_load_rd),
        .rs1           (dec_rs1),
        .rs2           (dec_rs2),
        .uses_rs1      (dec_uses_rs1),
        .uses_rs2      (dec_uses_rs2),
        .in_ready      (in_ready),
        .load_en       (load_en),
        .out_valid     (out_valid)
    );

    decode_out_reg i_decode_out_reg (
        .clk          (clk),
        .load_en      (load_en),
        .pc           (in_pc),
        .op_class     (dec_class),
        .funct3       (dec_funct3),
        .funct7       (dec_funct7),
        .rd           (dec_rd),
        .imm          (dec_imm),
        .rd_port      (rf_rd.requester),
        .out_pc       (out_pc),
        .out_class    (out_class),
        .out_funct3   (out_funct3),
        .out_funct7   (out_funct7),
        .out_rd       (out_rd),
        .out_imm      (out_imm),
        .out_rs1_data (out_rs1_data),
        .out_rs2_data (out_rs2_data)
    );

endmodule

`default_nettype wire

// File: tb/decode_stage_assertions.sv
// protocol checks for the decode stage control FSM, attached to every decode_ctrl instance by bind
`timescale 1ns/1ps
`default_nettype none

module decode_stage_assertions (
    input logic       clk,
    input logic       reset,
    input logic       in_valid,
    input logic       in_ready,
    input logic       out_valid,
    input logic       out_ready,
    input logic       load_en,
    input logic       ex_load_valid,
    input logic [4:0] ex_load_rd,
    input logic [4:0] rs1,
    input logic [4:0] rs2,
    input logic       uses_rs1,
    input logic       uses_rs2
);

    // load-use condition rebuilt from the control's inputs
    logic load_use;

    // nonzero load target matching any source the word reads
    assign load_use = ex_load_valid && ex_load_rd != 5'd0 &&
                      ((uses_rs1 && rs1 == ex_load_rd) ||
                       (uses_rs2 && rs2 == ex_load_rd));

    // a stalled output keeps its valid until taken
    a_valid_hold: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid
    ) else $error("out_valid dropped while out_ready was low");

    // no acceptance while the load in execute feeds a source
    a_hazard_stall: assert property (
        @(posedge clk) disable iff (reset)
        load_use |-> !in_ready
    ) else $error("in_ready high during a load-use hazard");

    // load only with a valid word, a free output slot and no hazard
    a_load_on_transfer: assert property (
        @(posedge clk) disable iff (reset)
        load_en |-> in_valid && (!out_valid || out_ready) && !load_use
    ) else $error("load_en raised without an input transfer");

endmodule

bind decode_ctrl decode_stage_assertions i_decode_stage_assertions (
    .clk           (clk),
    .reset         (reset),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .load_en       (load_en),
    .ex_load_valid (ex_load_valid),
    .ex_load_rd    (ex_load_rd),
    .rs1           (rs1),
    .rs2           (rs2),
    .uses_rs1      (uses_rs1),
    .uses_rs2      (uses_rs2)
);

`default_nettype wire

// File: tb/tb_decode_stage.sv
// testbench for the decode stage, random instructions checked against a reference model by assertions
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage import decode_pkg::*; ();

    localparam int num_instrs = 400;
    localparam int clk_period = 100;
    localparam int timeout_ns = (num_instrs * 4 + 10) * clk_period;

    // kept opcodes first, then fence, system and an unused code
    localparam logic [6:0] opcode_list [14] = '{
        7'b0110011, 7'b0111011, 7'b0010011, 7'b0011011, 7'b0000011, 7'b0100011,
        7'b1100011, 7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111,
        7'b0001111, 7'b1110011, 7'b1111111
    };

    // one expected result of the stage
    typedef struct packed {
        logic [63:0] pc;
        logic [2:0]  cls;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [4:0]  rd;
        logic [63:0] imm;
        logic [63:0] rs1_data;
        logic [63:0] rs2_data;
    } expect_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] in_instr;
    logic [63:0] in_pc;
    logic        wb_en;
    logic [4:0]  wb_rd;
    logic [63:0] wb_data;
    logic        ex_load_valid;
    logic [4:0]  ex_load_rd;
    logic        out_valid;
    logic        out_ready;
    logic [63:0] out_pc;
    op_class_e   out_class;
    logic [2:0]  out_funct3;
    logic [6:0]  out_funct7;
    logic [4:0]  out_rd;
    logic [63:0] out_imm;
    logic [63:0] out_rs1_data;
    logic [63:0] out_rs2_data;

    // reference model state
    integer      seed;
    logic [63:0] shadow [32];
    expect_t     exp_q [$];
    expect_t     head;
    logic        head_valid = 1'b0;
    int          issued = 0;
    int          accepted = 0;
    int          delivered = 0;
    logic [63:0] next_pc = 64'h1000;

    // decode of the word now on the input, for the stall rule
    logic [2:0]  h_cls;
    logic [4:0]  h_rd;
    logic [63:0] h_imm;
    logic        h_use1;
    logic        h_use2;
    logic        exp_hazard;
    logic        exp_in_ready;

    always #(clk_period / 2) clk = ~clk;

    decode_stage #(
        .num_regs (32)
    ) i_decode_stage (.*);

    task automatic fail_run();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("ERROR at %0t ns: %s expected %0h actual %0h", $time, name, expected, actual);
        fail_run();
    endtask

    // class, rd, immediate and sources straight from the ISA format rules
    function automatic void decode_expected(
        input  logic [31:0] w,
        output logic [2:0]  cls,
        output logic [4:0]  rd,
        output logic [63:0] imm,
        output logic        use1,
        output logic        use2
    );
        cls = cls_illegal;
        rd = w[11:7];
        imm = '0;
        use1 = 1'b0;
        use2 = 1'b0;
        case (w[6:0])
            7'b0110011, 7'b0111011: begin
                cls = cls_alu_reg;
                use1 = 1'b1;
                use2 = 1'b1;
            end
            7'b0010011, 7'b0011011: begin
                cls = cls_alu_imm;
                use1 = 1'b1;
                imm = {{52{w[31]}}, w[31:20]};
            end
            7'b0000011: begin
                cls = cls_load;
                use1 = 1'b1;
                imm = {{52{w[31]}}, w[31:20]};
            end
            7'b0100011: begin
                cls = cls_store;
                rd = 5'd0;
                use1 = 1'b1;
                use2 = 1'b1;
                imm = {{52{w[31]}}, w[31:25], w[11:7]};
            end
            7'b1100011: begin
                cls = cls_branch;
                rd = 5'd0;
                use1 = 1'b1;
                use2 = 1'b1;
                imm = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            7'b0110111, 7'b0010111: begin
                cls = cls_upper;
                imm = {{32{w[31]}}, w[31:12], 12'h000};
            end
            7'b1101111: begin
                cls = cls_jump;
                imm = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            7'b1100111: begin
                cls = cls_jump;
                use1 = 1'b1;
                imm = {{52{w[31]}}, w[31:20]};
            end
            default: begin
                cls = cls_illegal;
            end
        endcase
    endfunction

    // shadow read with x0 and same-cycle write-back applied
    function automatic logic [63:0] read_shadow(input logic [4:0] addr);
        logic [63:0] value;
        if (addr == 5'd0) begin
            value = '0;
        end else if (wb_en && wb_rd == addr) begin
            value = wb_data;
        end else begin
            value = shadow[addr];
        end
        return value;
    endfunction

    function automatic logic [31:0] make_instr();
        logic [31:0] w;
        int unsigned pick;
        w = $random(seed);
        pick = $unsigned($random(seed)) % 14;
        w[6:0] = opcode_list[pick];
        // sources kept in x0..x7 so write-back and hazards hit often
        w[19:18] = 2'b00;
        w[24:23] = 2'b00;
        return w;
    endfunction

    always_comb begin
        decode_expected(in_instr, h_cls, h_rd, h_imm, h_use1, h_use2);
        exp_hazard = ex_load_valid && ex_load_rd != 5'd0 &&
                     ((h_use1 && in_instr[19:15] == ex_load_rd) ||
                      (h_use2 && in_instr[24:20] == ex_load_rd));
        exp_in_ready = (!head_valid || out_ready) && !exp_hazard;
    end

    // model: queue of expected outputs in input order, shadow register file
    always @(posedge clk) begin
        expect_t e;
        logic u1;
        logic u2;
        if (reset) begin
            exp_q.delete();
            for (int i = 0; i < 32; i++) begin
                shadow[i] = '0;
            end
        end else begin
            // pop first, a refill on the same edge goes behind it
            if (out_valid && out_ready && exp_q.size() != 0) begin
                void'(exp_q.pop_front());
                delivered++;
            end
            if (in_valid && in_ready) begin
                e.pc = in_pc;
                decode_expected(in_instr, e.cls, e.rd, e.imm, u1, u2);
                e.funct3 = in_instr[14:12];
                e.funct7 = in_instr[31:25];
                e.rs1_data = read_shadow(in_instr[19:15]);
                e.rs2_data = read_shadow(in_instr[24:20]);
                exp_q.push_back(e);
                accepted++;
            end
            if (wb_en && wb_rd != 5'd0) begin
                shadow[wb_rd] = wb_data;
            end
        end
        head_valid <= exp_q.size() != 0;
        if (exp_q.size() != 0) begin
            head <= exp_q[0];
        end
    end

    a_reset_empty: assert property (@(posedge clk) reset |=> !out_valid)
        else report_mismatch("out_valid", 64'd0, $sampled(out_valid));
    a_out_valid: assert property (@(posedge clk) disable iff (reset) out_valid == head_valid)
        else report_mismatch("out_valid", $sampled(head_valid), $sampled(out_valid));
    a_in_ready: assert property (@(posedge clk) disable iff (reset) in_ready == exp_in_ready)
        else report_mismatch("in_ready", $sampled(exp_in_ready), $sampled(in_ready));
    a_pc: assert property (@(posedge clk) disable iff (reset) out_valid |-> out_pc == head.pc)
        else report_mismatch("out_pc", $sampled(head.pc), $sampled(out_pc));
    a_class: assert property (@(posedge clk) disable iff (reset)
                              out_valid |-> out_class == head.cls)
        else report_mismatch("out_class", $sampled(head.cls), $sampled(out_class));
    a_funct3: assert property (@(posedge clk) disable iff (reset)
                               out_valid |-> out_funct3 == head.funct3)
        else report_mismatch("out_funct3", $sampled(head.funct3), $sampled(out_funct3));
    a_funct7: assert property (@(posedge clk) disable iff (reset)
                               out_valid |-> out_funct7 == head.funct7)
        else report_mismatch("out_funct7", $sampled(head.funct7), $sampled(out_funct7));
    a_rd: assert property (@(posedge clk) disable iff (reset) out_valid |-> out_rd == head.rd)
        else report_mismatch("out_rd", $sampled(head.rd), $sampled(out_rd));
    a_imm: assert property (@(posedge clk) disable iff (reset) out_valid |-> out_imm == head.imm)
        else report_mismatch("out_imm", $sampled(head.imm), $sampled(out_imm));
    a_rs1: assert property (@(posedge clk) disable iff (reset)
                            out_valid |-> out_rs1_data == head.rs1_data)
        else report_mismatch("out_rs1_data", $sampled(head.rs1_data), $sampled(out_rs1_data));
    a_rs2: assert property (@(posedge clk) disable iff (reset)
                            out_valid |-> out_rs2_data == head.rs2_data)
        else report_mismatch("out_rs2_data", $sampled(head.rs2_data), $sampled(out_rs2_data));

    // one edge of stimulus, in_ready read before the edge takes effect
    task automatic drive_cycle();
        int r;
        logic [31:0] w;
        r = $random(seed);
        w = in_instr;
        // word on the input is used up if it just transferred or was never valid
        if (!in_valid || in_ready) begin
            if (issued < num_instrs && r[13:12] != 2'b00) begin
                w = make_instr();
                in_instr <= w;
                in_pc <= next_pc;
                in_valid <= 1'b1;
                next_pc = next_pc + 64'd4;
                issued++;
            end else begin
                in_valid <= 1'b0;
            end
        end
        wb_en <= r[0];
        wb_rd <= {2'b00, r[3:1]};
        wb_data <= {$random(seed), $random(seed)};
        out_ready <= (r[5:4] != 2'b00);
        ex_load_valid <= r[6];
        // half the time the load targets a source of the presented word
        if (r[7]) begin
            ex_load_rd <= r[8] ? w[19:15] : w[24:20];
        end else begin
            ex_load_rd <= {2'b00, r[11:9]};
        end
    endtask

    initial begin
        seed = 26946;
        reset = 1'b1;
        in_valid = 1'b0;
        in_instr = '0;
        in_pc = '0;
        wb_en = 1'b0;
        wb_rd = '0;
        wb_data = '0;
        ex_load_valid = 1'b0;
        ex_load_rd = '0;
        out_ready = 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        while (delivered < num_instrs) begin
            @(posedge clk);
            drive_cycle();
        end
        // quiet tail, a stray out_valid trips the assertions
        repeat (5) begin
            @(posedge clk);
            out_ready <= 1'b1;
            ex_load_valid <= 1'b0;
            wb_en <= 1'b0;
        end
        if (accepted != num_instrs || exp_q.size() != 0) begin
            $display("stage accepted %0d of %0d instructions, %0d still expected",
                     accepted, num_instrs, exp_q.size());
            fail_run();
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

    // watchdog, about four cycles per instruction
    initial begin
        #(timeout_ns);
        $display("timeout: only %0d of %0d instructions delivered after %0d ns",
                 delivered, num_instrs, timeout_ns);
        fail_run();
    end

endmodule

`default_nettype wire

// File: riscv_decode.f
hdl/decode_pkg.sv
hdl/regfile_read_if.sv
hdl/instr_decoder.sv
hdl/reg_file.sv
hdl/decode_ctrl.sv
hdl/decode_out_reg.sv
hdl/decode_stage.sv
tb/decode_stage_assertions.sv
tb/tb_decode_stage.sv

// File: run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f riscv_decode.f --top-module tb_decode_stage -o sim_decode_stage

status=0
./obj_dir/sim_decode_stage > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "RESULT: PASS" sim.log; then
    echo "simulation ended without a pass result"
    exit 1
fi
echo "simulation passed"
